// ==== common/fp_pkg.sv ====
package fp_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    localparam int N_LOG      = 8;
    localparam int W_LCHAN    = 5;
    localparam int W_LDATA    = 18;
    localparam int W_EP       = 16;
    localparam int W_WR_ADDR  = 16;
    localparam int W_WR_CHAN  = 5;
    localparam int W_WR_DATA  = 49;

    // Index into the log register array
    localparam int LOG_IDX_W  = $clog2(N_LOG);

    // Pipe FIFO sizing
    localparam int PIPE_DEPTH = 64;
    localparam int W_PIPE_PTR = $clog2(PIPE_DEPTH);
    // One extra bit so a full FIFO is distinct from empty
    localparam int W_PIPE_CNT = W_PIPE_PTR + 1;

    // AXI4-Lite bus widths
    localparam int W_AXI_ADDR = 8;
    localparam int W_AXI_DATA = 32;

    // ----------------------------------------
    // Register map, byte addresses
    // ----------------------------------------
    localparam logic [W_AXI_ADDR-1:0] REG_TRIG      = 8'h00;
    localparam logic [W_AXI_ADDR-1:0] REG_WR_ADDR   = 8'h04;
    localparam logic [W_AXI_ADDR-1:0] REG_WR_CHAN   = 8'h08;
    localparam logic [W_AXI_ADDR-1:0] REG_DATA0     = 8'h0C;
    localparam logic [W_AXI_ADDR-1:0] REG_DATA1     = 8'h10;
    localparam logic [W_AXI_ADDR-1:0] REG_DATA2     = 8'h14;
    localparam logic [W_AXI_ADDR-1:0] REG_DATA3     = 8'h18;
    localparam logic [W_AXI_ADDR-1:0] REG_LOG_BASE  = 8'h40;
    localparam logic [W_AXI_ADDR-1:0] REG_PIPE_DATA = 8'h80;
    localparam logic [W_AXI_ADDR-1:0] REG_PIPE_STAT = 8'h84;

    // Byte stride between log channel registers
    localparam int LOG_STRIDE = 4;

    // Trigger register bit positions
    localparam int ADC_CSTART_BIT = 1;
    localparam int WR_EN_BIT      = 2;
    localparam int DAC_RSET_BIT   = 3;

    // Command address that selects the pipe channel
    localparam logic [W_WR_ADDR-1:0] PIPE_CSET_RQST = 16'h0004;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Host data word, four host words or one command value
    typedef union packed {
        logic [3:0][W_EP-1:0] words;
        struct packed {
            logic [14:0]          pad;
            logic [W_WR_DATA-1:0] value;
        } cmd;
    } wr_word_u;

endpackage

// ==== frontpanel/axil_host_port.sv ====
module axil_host_port
    import fp_pkg::*;
(
    input  logic                  pid_clk_in,
    input  logic                  sys_rst_out,

    // AXI4-Lite write channels
    input  logic [W_AXI_ADDR-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [W_AXI_DATA-1:0] wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,

    // AXI4-Lite read channels
    input  logic [W_AXI_ADDR-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [W_AXI_DATA-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,

    // Read sources
    input  logic [W_EP-1:0]       cmd_rd_data,
    input  logic                  cmd_rd_hit,
    input  logic [W_EP-1:0]       log_rd_data,
    input  logic                  log_rd_hit,

    // Register strobes to the blocks
    output logic                  reg_wr,
    output logic [W_AXI_ADDR-1:0] reg_wr_addr,
    output logic [W_EP-1:0]       reg_wr_data,
    output logic [W_AXI_ADDR-1:0] rd_addr,
    output logic                  pipe_pop
);

    logic            wr_accept;
    logic            wr_map_hit;
    logic            rd_accept;
    logic [W_EP-1:0] rd_word;
    logic [1:0]      rd_resp;

    // ----------------------------------------
    // Write path
    // ----------------------------------------

    // Address and data taken together, blocked while a response waits
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    // Writable part of the map
    assign wr_map_hit = (awaddr == REG_TRIG)    ||
                        (awaddr == REG_WR_ADDR) ||
                        (awaddr == REG_WR_CHAN) ||
                        (awaddr == REG_DATA0)   ||
                        (awaddr == REG_DATA1)   ||
                        (awaddr == REG_DATA2)   ||
                        (awaddr == REG_DATA3);

    // Strobe only for mapped addresses
    assign reg_wr      = wr_accept && wr_map_hit;
    assign reg_wr_addr = awaddr;
    // Upper bus bits carry nothing
    assign reg_wr_data = wdata[W_EP-1:0];

    // Write response valid
    always_ff @(posedge pid_clk_in) begin
        if (sys_rst_out) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Response code, held until bready
    always_ff @(posedge pid_clk_in) begin
        if (wr_accept) begin
            bresp <= wr_map_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------

    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;
    assign rd_addr   = araddr;

    // FIFO head advances with the accepted read
    assign pipe_pop  = rd_accept && (araddr == REG_PIPE_DATA);

    // Pick whichever block claims the address
    always_comb begin
        rd_word = '0;
        rd_resp = RESP_SLVERR;
        if (cmd_rd_hit) begin
            rd_word = cmd_rd_data;
            rd_resp = RESP_OKAY;
        end else if (log_rd_hit) begin
            rd_word = log_rd_data;
            rd_resp = RESP_OKAY;
        end
    end

    // Read response valid
    always_ff @(posedge pid_clk_in) begin
        if (sys_rst_out) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Read payload, zero extended to the bus width
    always_ff @(posedge pid_clk_in) begin
        if (rd_accept) begin
            rdata <= W_AXI_DATA'(rd_word);
            rresp <= rd_resp;
        end
    end

endmodule

// ==== frontpanel/command_regs.sv ====
module command_regs
    import fp_pkg::*;
(
    input  logic                  pid_clk_in,
    input  logic                  sys_rst_out,

    // Strobes from the host port
    input  logic                  reg_wr,
    input  logic [W_AXI_ADDR-1:0] reg_wr_addr,
    input  logic [W_EP-1:0]       reg_wr_data,
    input  logic [W_AXI_ADDR-1:0] rd_addr,

    // Read back
    output logic [W_EP-1:0]       cmd_rd_data,
    output logic                  cmd_rd_hit,

    // Command outputs to the PID core
    output logic [W_WR_ADDR-1:0]  wr_addr,
    output logic [W_WR_CHAN-1:0]  wr_chan,
    output logic [W_WR_DATA-1:0]  wr_data,
    output logic                  adc_cstart,
    output logic                  wr_en,
    output logic                  dac_rset,

    // Selected channel for the log FIFO
    output logic [W_LCHAN-1:0]    pipe_chan
);

    wr_word_u data_q;
    logic     trig_wr;

    // ----------------------------------------
    // Command registers
    // ----------------------------------------
    always_ff @(posedge pid_clk_in) begin
        if (sys_rst_out) begin
            wr_addr <= '0;
            wr_chan <= '0;
            data_q  <= '0;
        end else if (reg_wr) begin
            case (reg_wr_addr)
                REG_WR_ADDR: wr_addr <= reg_wr_data[W_WR_ADDR-1:0];
                REG_WR_CHAN: wr_chan <= reg_wr_data[W_WR_CHAN-1:0];
                // Word 0 is least significant
                REG_DATA0:   data_q.words[0] <= reg_wr_data;
                REG_DATA1:   data_q.words[1] <= reg_wr_data;
                REG_DATA2:   data_q.words[2] <= reg_wr_data;
                REG_DATA3:   data_q.words[3] <= reg_wr_data;
                default: ;
            endcase
        end
    end

    // Command value view of the four words
    assign wr_data = data_q.cmd.value;

    // ----------------------------------------
    // Trigger pulses
    // ----------------------------------------
    assign trig_wr = reg_wr && (reg_wr_addr == REG_TRIG);

    // One cycle each, nothing stored
    always_ff @(posedge pid_clk_in) begin
        if (sys_rst_out) begin
            adc_cstart <= 1'b0;
            wr_en      <= 1'b0;
            dac_rset   <= 1'b0;
        end else begin
            adc_cstart <= trig_wr && reg_wr_data[ADC_CSTART_BIT];
            wr_en      <= trig_wr && reg_wr_data[WR_EN_BIT];
            dac_rset   <= trig_wr && reg_wr_data[DAC_RSET_BIT];
        end
    end

    // Pipe channel select on a wr_en with the request address
    always_ff @(posedge pid_clk_in) begin
        if (sys_rst_out) begin
            pipe_chan <= '0;
        end else if (wr_en && (wr_addr == PIPE_CSET_RQST)) begin
            pipe_chan <= wr_chan[W_LCHAN-1:0];
        end
    end

    // Read back mux, trigger register always zero
    always_comb begin
        cmd_rd_data = '0;
        cmd_rd_hit  = 1'b1;
        case (rd_addr)
            REG_TRIG:    cmd_rd_data = '0;
            REG_WR_ADDR: cmd_rd_data = W_EP'(wr_addr);
            REG_WR_CHAN: cmd_rd_data = W_EP'(wr_chan);
            REG_DATA0:   cmd_rd_data = data_q.words[0];
            REG_DATA1:   cmd_rd_data = data_q.words[1];
            REG_DATA2:   cmd_rd_data = data_q.words[2];
            REG_DATA3:   cmd_rd_data = data_q.words[3];
            default:     cmd_rd_hit  = 1'b0;
        endcase
    end

endmodule

// ==== frontpanel/log_capture.sv ====
module log_capture
    import fp_pkg::*;
(
    input  logic                  pid_clk_in,
    input  logic                  sys_rst_out,

    // Log sample stream
    input  logic                  log_dv,
    input  logic [W_LCHAN-1:0]    log_chan,
    input  logic [W_LDATA-1:0]    log_data,

    // Pipe control
    input  logic [W_LCHAN-1:0]    pipe_chan,
    input  logic                  pipe_pop,

    // Read side
    input  logic [W_AXI_ADDR-1:0] rd_addr,
    output logic [W_EP-1:0]       log_rd_data,
    output logic                  log_rd_hit
);

    logic [N_LOG-1:0][W_LDATA-1:0] log_reg;
    logic [PIPE_DEPTH-1:0][W_EP-1:0] pipe_mem;

    logic [W_PIPE_PTR-1:0] wr_ptr;
    logic [W_PIPE_PTR-1:0] rd_ptr;
    logic [W_PIPE_CNT-1:0] count;
    logic                  ovf;

    logic                  chan_ok;
    logic                  push;
    logic                  push_ok;
    logic                  pop_ok;
    logic                  full;
    logic [W_AXI_ADDR-1:0] log_off;
    logic [LOG_IDX_W-1:0]  log_idx;

    // ----------------------------------------
    // Latest value per channel
    // ----------------------------------------
    assign chan_ok = (log_chan < W_LCHAN'(N_LOG));

    always_ff @(posedge pid_clk_in) begin
        if (sys_rst_out) begin
            log_reg <= '0;
        end else if (log_dv && chan_ok) begin
            log_reg[log_chan[LOG_IDX_W-1:0]] <= log_data;
        end
    end

    // ----------------------------------------
    // Selected channel FIFO
    // ----------------------------------------
    assign full    = (count == W_PIPE_CNT'(PIPE_DEPTH));
    assign push    = log_dv && chan_ok && (log_chan == pipe_chan);
    // Full FIFO drops the new sample
    assign push_ok = push && !full;
    // Pop on empty only returns zero
    assign pop_ok  = pipe_pop && (count != '0);

    always_ff @(posedge pid_clk_in) begin
        if (sys_rst_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Count holds when push and pop coincide
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
            // Sticky until reset
            if (push && full) begin
                ovf <= 1'b1;
            end
        end
    end

    // Upper bits of the sample
    always_ff @(posedge pid_clk_in) begin
        if (push_ok) begin
            pipe_mem[wr_ptr] <= log_data[W_LDATA-1 -: W_EP];
        end
    end

    // ----------------------------------------
    // Read decode
    // ----------------------------------------
    assign log_off = rd_addr - REG_LOG_BASE;
    assign log_idx = LOG_IDX_W'(log_off / LOG_STRIDE);

    always_comb begin
        log_rd_data = '0;
        log_rd_hit  = 1'b0;
        if (rd_addr == REG_PIPE_DATA) begin
            log_rd_hit  = 1'b1;
            log_rd_data = (count != '0) ? pipe_mem[rd_ptr] : '0;
        end else if (rd_addr == REG_PIPE_STAT) begin
            log_rd_hit                   = 1'b1;
            log_rd_data[W_PIPE_CNT-1:0]  = count;
            log_rd_data[W_EP-1]          = ovf;
        end else if ((rd_addr >= REG_LOG_BASE) &&
                     (log_off < W_AXI_ADDR'(N_LOG * LOG_STRIDE)) &&
                     (log_off % LOG_STRIDE == 0)) begin
            // Channel register, upper 16 of 18 bits
            log_rd_hit  = 1'b1;
            log_rd_data = log_reg[log_idx][W_LDATA-1 -: W_EP];
        end
    end

endmodule

// ==== source/frontpanel_interface.sv ====
module frontpanel_interface
    import fp_pkg::*;
(
    input  logic                    pid_clk_in,
    input  logic                    sys_rst_out,

    // AXI4-Lite slave
    input  logic [W_AXI_ADDR-1:0]   awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [W_AXI_DATA-1:0]   wdata,
    input  logic [W_AXI_DATA/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [W_AXI_ADDR-1:0]   araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [W_AXI_DATA-1:0]   rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,

    // Log samples from the PID core
    input  logic                    log_dv,
    input  logic [W_LCHAN-1:0]      log_chan,
    input  logic [W_LDATA-1:0]      log_data,

    // Commands to the PID core
    output logic                    adc_cstart,
    output logic                    wr_en,
    output logic                    dac_rset,
    output logic [W_WR_ADDR-1:0]    wr_addr,
    output logic [W_WR_CHAN-1:0]    wr_chan,
    output logic [W_WR_DATA-1:0]    wr_data
);

    // Host port to blocks
    logic                  reg_wr;
    logic [W_AXI_ADDR-1:0] reg_wr_addr;
    logic [W_EP-1:0]       reg_wr_data;
    logic [W_AXI_ADDR-1:0] rd_addr;
    logic                  pipe_pop;

    // Blocks back to host port
    logic [W_EP-1:0]       cmd_rd_data;
    logic                  cmd_rd_hit;
    logic [W_EP-1:0]       log_rd_data;
    logic                  log_rd_hit;
    logic [W_LCHAN-1:0]    pipe_chan;

    // Byte strobes have no effect on 16-bit registers
    axil_host_port u_host (
        .pid_clk_in  (pid_clk_in),
        .sys_rst_out (sys_rst_out),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .cmd_rd_data (cmd_rd_data),
        .cmd_rd_hit  (cmd_rd_hit),
        .log_rd_data (log_rd_data),
        .log_rd_hit  (log_rd_hit),
        .reg_wr      (reg_wr),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .rd_addr     (rd_addr),
        .pipe_pop    (pipe_pop)
    );

    command_regs u_cmd (
        .pid_clk_in  (pid_clk_in),
        .sys_rst_out (sys_rst_out),
        .reg_wr      (reg_wr),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .rd_addr     (rd_addr),
        .cmd_rd_data (cmd_rd_data),
        .cmd_rd_hit  (cmd_rd_hit),
        .wr_addr     (wr_addr),
        .wr_chan     (wr_chan),
        .wr_data     (wr_data),
        .adc_cstart  (adc_cstart),
        .wr_en       (wr_en),
        .dac_rset    (dac_rset),
        .pipe_chan   (pipe_chan)
    );

    log_capture u_log (
        .pid_clk_in  (pid_clk_in),
        .sys_rst_out (sys_rst_out),
        .log_dv      (log_dv),
        .log_chan    (log_chan),
        .log_data    (log_data),
        .pipe_chan   (pipe_chan),
        .pipe_pop    (pipe_pop),
        .rd_addr     (rd_addr),
        .log_rd_data (log_rd_data),
        .log_rd_hit  (log_rd_hit)
    );

endmodule

// ==== tb/tb_frontpanel.sv ====
module tb_frontpanel
    import fp_pkg::*;
();

    localparam int    NAME_W    = 8 * 24;
    localparam string DATA_FILE = "tb/fp_testdata.txt";

    logic                    pid_clk_in;
    logic                    sys_rst_out;
    logic [W_AXI_ADDR-1:0]   awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [W_AXI_DATA-1:0]   wdata;
    logic [W_AXI_DATA/8-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [W_AXI_ADDR-1:0]   araddr;
    logic                    arvalid;
    logic                    arready;
    logic [W_AXI_DATA-1:0]   rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    logic                    log_dv;
    logic [W_LCHAN-1:0]      log_chan;
    logic [W_LDATA-1:0]      log_data;
    logic                    adc_cstart;
    logic                    wr_en;
    logic                    dac_rset;
    logic [W_WR_ADDR-1:0]    wr_addr;
    logic [W_WR_CHAN-1:0]    wr_chan;
    logic [W_WR_DATA-1:0]    wr_data;

    int         seed;
    int         watch_cycles;
    // Trigger pulses seen since the last write in register bit layout
    logic [3:0] trig_seen;
    logic [3:0] trig_last;
    logic [3:0] trig_long;

    frontpanel_interface u_dut (.*);

    initial begin
        pid_clk_in = 1'b0;
        forever #2 pid_clk_in = ~pid_clk_in;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input logic [NAME_W-1:0] name, input logic [W_EP-1:0] exp,
                              input logic [W_EP-1:0] act);
        if (act !== exp) begin
            $display("ERR %0s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(input logic [NAME_W-1:0] name, input logic [1:0] exp,
                              input logic [1:0] act);
        if (act !== exp) begin
            $display("ERR %0s expected resp %b actual resp %b", name, exp, act);
            abort_run();
        end
    endtask

    // Only the 49-bit command view counts
    task automatic check_data(input logic [NAME_W-1:0] name, input wr_word_u exp,
                              input wr_word_u act);
        if (act.cmd.value !== exp.cmd.value) begin
            $display("ERR %0s expected %h actual %h", name, exp.cmd.value, act.cmd.value);
            abort_run();
        end
    endtask

    task automatic check_trig(input logic [NAME_W-1:0] name, input logic [3:0] exp,
                              input logic [3:0] act);
        if (act !== exp) begin
            $display("ERR %0s expected triggers %b actual triggers %b", name, exp, act);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // Bus and sample drivers
    // ----------------------------------------
    task automatic note_triggers();
        logic [3:0] cur;
        cur                 = '0;
        cur[ADC_CSTART_BIT] = adc_cstart;
        cur[WR_EN_BIT]      = wr_en;
        cur[DAC_RSET_BIT]   = dac_rset;
        // High on two samples in a row means a stretched pulse
        trig_long = trig_long | (cur & trig_last);
        trig_seen = trig_seen | cur;
        trig_last = cur;
    endtask

    task automatic step_cycle();
        @(negedge pid_clk_in);
        note_triggers();
    endtask

    task automatic write_reg(input logic [W_AXI_ADDR-1:0] addr,
                             input logic [W_AXI_DATA-1:0] data, output logic [1:0] resp);
        int stall;
        trig_seen = '0;
        trig_last = '0;
        trig_long = '0;
        awaddr    = addr;
        wdata     = data;
        awvalid   = 1'b1;
        wvalid    = 1'b1;
        // Both ready lines high in the acceptance cycle
        #1;
        if (!awready || !wready) begin
            $display("Write was not accepted while no response was pending");
            abort_run();
        end
        step_cycle();
        // Response one cycle after acceptance
        if (!bvalid) begin
            $display("Write response did not arrive one cycle after acceptance");
            abort_run();
        end
        if (awready || wready) begin
            $display("Write ready lines stayed high after acceptance");
            abort_run();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        stall   = $random(seed) & 3;
        repeat (stall) begin
            step_cycle();
            if (!bvalid || bresp !== resp) begin
                $display("Write response changed while bready was held low");
                abort_run();
            end
        end
        bready = 1'b1;
        step_cycle();
        bready = 1'b0;
        if (bvalid) begin
            $display("Write response still valid after bready was given");
            abort_run();
        end
    endtask

    task automatic read_reg(input logic [W_AXI_ADDR-1:0] addr,
                            output logic [W_AXI_DATA-1:0] data, output logic [1:0] resp);
        int stall;
        araddr  = addr;
        arvalid = 1'b1;
        // Address taken at once with no response pending
        #1;
        if (!arready) begin
            $display("Read was not accepted while no response was pending");
            abort_run();
        end
        step_cycle();
        if (!rvalid) begin
            $display("Read response did not arrive one cycle after acceptance");
            abort_run();
        end
        if (arready) begin
            $display("Read ready line stayed high after acceptance");
            abort_run();
        end
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        stall   = $random(seed) & 3;
        repeat (stall) begin
            step_cycle();
            if (!rvalid || rdata !== data || rresp !== resp) begin
                $display("Read response changed while rready was held low");
                abort_run();
            end
        end
        rready = 1'b1;
        step_cycle();
        rready = 1'b0;
        if (rvalid) begin
            $display("Read response still valid after rready was given");
            abort_run();
        end
    endtask

    task automatic send_sample(input logic [W_LCHAN-1:0] chan, input logic [W_LDATA-1:0] data);
        log_chan = chan;
        log_data = data;
        log_dv   = 1'b1;
        @(negedge pid_clk_in);
        log_dv   = 1'b0;
    endtask

    // Back-to-back samples stepping by 4 so the popped word steps by 1
    task automatic send_burst(input logic [W_LCHAN-1:0] chan, input int count,
                              input logic [W_LDATA-1:0] first);
        for (int i = 0; i < count; i++) begin
            log_chan = chan;
            log_data = first + W_LDATA'(4 * i);
            log_dv   = 1'b1;
            @(negedge pid_clk_in);
        end
        log_dv = 1'b0;
    endtask

    task automatic apply_reset();
        sys_rst_out = 1'b1;
        repeat (2) @(negedge pid_clk_in);
        sys_rst_out = 1'b0;
    endtask

    // ----------------------------------------
    // One stimulus line
    // ----------------------------------------
    task automatic run_line(input logic [7:0] op, input logic [NAME_W-1:0] name,
                            input logic [63:0] f1, input logic [63:0] f2,
                            input logic [63:0] f3);
        logic [1:0]            resp;
        logic [W_AXI_DATA-1:0] data;
        wr_word_u              exp_u;
        wr_word_u              act_u;
        case (op)
            "W": begin
                write_reg(f1[W_AXI_ADDR-1:0], f2[W_AXI_DATA-1:0], resp);
                check_resp(name, f3[1:0], resp);
            end
            "R": begin
                read_reg(f1[W_AXI_ADDR-1:0], data, resp);
                check_word(name, f2[W_EP-1:0], data[W_EP-1:0]);
                // Upper half of the bus stays zero
                check_word(name, '0, data[W_AXI_DATA-1:W_EP]);
                check_resp(name, f3[1:0], resp);
            end
            "L": send_sample(f1[W_LCHAN-1:0], f2[W_LDATA-1:0]);
            "B": send_burst(f1[W_LCHAN-1:0], int'(f2), f3[W_LDATA-1:0]);
            "T": begin
                check_trig(name, f1[3:0], trig_seen);
                if (trig_long != '0) begin
                    $display("A trigger in %0s stayed high for more than one cycle", name);
                    abort_run();
                end
            end
            "O": begin
                exp_u           = '0;
                act_u           = '0;
                exp_u.cmd.value = f3[W_WR_DATA-1:0];
                act_u.cmd.value = wr_data;
                check_word(name, f1[W_EP-1:0], wr_addr);
                check_word(name, W_EP'(f2[W_WR_CHAN-1:0]), W_EP'(wr_chan));
                check_data(name, exp_u, act_u);
            end
            "Z": apply_reset();
            default: begin
                $display("Unknown operation code in the stimulus file");
                abort_run();
            end
        endcase
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : run_tests
        int                fd;
        int                n;
        int                line_count;
        logic [1023:0]     line_buf;
        logic [7:0]        op;
        logic [NAME_W-1:0] name;
        logic [63:0]       f1;
        logic [63:0]       f2;
        logic [63:0]       f3;
        sys_rst_out = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '1;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        log_dv      = 1'b0;
        log_chan    = '0;
        log_data    = '0;
        trig_seen   = '0;
        trig_last   = '0;
        trig_long   = '0;
        seed        = 32'he956_c594;
        line_count  = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", DATA_FILE);
            abort_run();
        end
        // First pass only sizes the watchdog
        while ($fgets(line_buf, fd) != 0) begin
            line_count++;
        end
        $fclose(fd);
        watch_cycles = line_count * 40 + 100;
        apply_reset();
        fd = $fopen(DATA_FILE, "r");
        while ($fgets(line_buf, fd) != 0) begin
            n = $sscanf(line_buf, "%s %s %h %h %h", op, name, f1, f2, f3);
            // Header and blank lines carry no operation
            if (n >= 1 && op != "#") begin
                if (n != 5) begin
                    $display("Malformed line in the stimulus file");
                    abort_run();
                end
                run_line(op, name, f1, f2, f3);
            end
        end
        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : watchdog
        wait (watch_cycles != 0);
        repeat (watch_cycles) @(posedge pid_clk_in);
        $display("Run did not finish within %0d cycles", watch_cycles);
        abort_run();
    end

endmodule

// ==== tb/fp_testdata.txt ====
# op name f1 f2 f3, hex. W: addr wdata resp  R: addr rdata resp  L: chan sample x
# B: chan count first_sample  T: trigger bits x x  O: wr_addr wr_chan wr_data  Z: reset
W set_addr 04 00001234 0
W set_chan 08 00000013 0
W set_d0 0C a5a5beef 0
W set_d1 10 0000cafe 0
W set_d2 14 00005a5a 0
W set_d3 18 0000ffff 0
R get_addr 04 1234 0
R get_chan 08 0013 0
R get_d0 0C beef 0
R get_d1 10 cafe 0
R get_d3 18 ffff 0
O cmd_out 1234 13 15a5acafebeef
W trig_adc 00 00000002 0
T trig_adc 2 0 0
W trig_all 00 0000000f 0
T trig_all e 0 0
R trig_zero 00 0000 0
W bad_wr 20 00000055 2
W bad_log_wr 40 00000055 2
R bad_rd 30 0000 2
R bad_rd_hi 88 0000 2
O cmd_kept 1234 13 15a5acafebeef
W sel_addr 04 00000004 0
W sel_chan 08 00000005 0
W sel_fire 00 00000004 0
T sel_fire 4 0 0
L pipe_s0 05 01234 0
L log_c3 03 12345 0
L pipe_s1 05 35678 0
L log_c3_new 03 2abcd 0
L log_c0 00 3fffc 0
L log_c8 08 11111 0
L log_c9 09 3ffff 0
R get_log0 40 ffff 0
R get_log1 44 0000 0
R get_log3 4C aaf3 0
R pipe_cnt2 84 0002 0
R pipe_pop0 80 048d 0
R pipe_pop1 80 d59e 0
R pipe_empty 80 0000 0
B pipe_fill 05 41 00400
R pipe_full 84 8040 0
R pipe_first 80 0100 0
R pipe_second 80 0101 0
Z mid_reset 0 0 0
R rst_stat 84 0000 0
R rst_d3 18 0000 0
R rst_log3 4C 0000 0
O rst_cmd 0000 00 0

// ==== project.f ====
common/fp_pkg.sv
frontpanel/axil_host_port.sv
frontpanel/command_regs.sv
frontpanel/log_capture.sv
source/frontpanel_interface.sv
tb/tb_frontpanel.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_frontpanel
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

# Build, run, then decide on the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
